//--- DramCmdPkg.sv
// Command encoding, bus widths and queue payloads of the DRAM command interface
// Shared by the join unit, the synthetic DRAM and the testbench
package DramCmdPkg;

	// ------------------------------------------------------------------------
	// Command encoding
	// ------------------------------------------------------------------------

	localparam int DramCmdWidth = 3;

	// Same values as the DDR3 controller app_cmd field
	localparam logic [DramCmdWidth-1:0] DramCmdWrite = 3'd0;
	localparam logic [DramCmdWidth-1:0] DramCmdRead = 3'd1; // Other codes also read

	// ------------------------------------------------------------------------
	// Bus widths
	// ------------------------------------------------------------------------

	localparam int DramAddrWidth = 10; // Word address
	localparam int DramDataWidth = 64;
	localparam int DramMaskWidth = DramDataWidth / 8; // Set bit keeps old byte

	// ------------------------------------------------------------------------
	// Queue payloads
	// ------------------------------------------------------------------------

	// 13 bits
	typedef struct packed {
		logic [DramCmdWidth-1:0] command;
		logic [DramAddrWidth-1:0] address;
	} dramCmdEntry;

	// 72 bits
	typedef struct packed {
		logic [DramDataWidth-1:0] data;
		logic [DramMaskWidth-1:0] mask;
	} dramWriteEntry;

endpackage

//--- DramModelPkg.sv
// Sizing and timing of the synthetic DRAM model
// Queue depths and read latency follow the DDR3 controller it stands in for
package DramModelPkg;

	// ------------------------------------------------------------------------
	// Queue depths
	// ------------------------------------------------------------------------

	localparam int CmdQueueDepth = 6;
	localparam int WriteQueueDepth = 16;

	// ------------------------------------------------------------------------
	// Timing and size
	// ------------------------------------------------------------------------

	// Cycles from execution of a read to its data leaving the pipeline
	localparam int ReadLatency = 25;

	// One word per address
	localparam int MemWords = 1 << DramCmdPkg::DramAddrWidth;

endpackage

//--- DramQueue.sv
// Synchronous FIFO with valid/ready on both sides and a free payload type
// Head entry is read combinationally, so a push is visible right after its edge
module DramQueue #(
	parameter type payloadType = logic,
	parameter int Depth = 4
) (
	input  logic MemoryClock,
	input  logic arstN,

	input  logic pushValid,
	input  payloadType pushData,
	output logic pushReady,

	output logic popValid,
	output payloadType popData,
	input  logic popReady
);

	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountWidth = $clog2(Depth + 1);

	payloadType entries [Depth];

	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count;

	logic doPush;
	logic doPop;

	assign pushReady = (count != CountWidth'(Depth));
	assign popValid = (count != '0);
	assign popData = entries[rdPtr];

	assign doPush = pushValid & pushReady;
	assign doPop = popValid & popReady;

	// Storage, no reset needed on payload
	always_ff @(posedge MemoryClock) begin
		if (doPush)
			entries[wrPtr] <= pushData;
	end

	always_ff @(posedge MemoryClock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1; // Wrap at Depth
			if (doPop)
				rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Idle or push and pop together
			endcase
		end
	end

endmodule

//--- WriteJoin.sv
// Joins the command and write-data channels in front of the DRAM
// A write command and its data are handed over in one and the same cycle
module WriteJoin (
	// From the requester
	input  logic [DramCmdPkg::DramCmdWidth-1:0] Command,
	input  logic [DramCmdPkg::DramAddrWidth-1:0] Address,
	input  logic CommandValid,
	output logic CommandReady,

	input  logic [DramCmdPkg::DramDataWidth-1:0] WriteData,
	input  logic [DramCmdPkg::DramMaskWidth-1:0] WriteMask,
	input  logic WriteDataValid,
	output logic WriteDataReady,

	// Towards the DRAM
	output logic [DramCmdPkg::DramCmdWidth-1:0] dramCmd,
	output logic [DramCmdPkg::DramAddrWidth-1:0] dramAddr,
	output logic dramCmdValid,
	input  logic dramCmdReady,

	output logic [DramCmdPkg::DramDataWidth-1:0] dramWrData,
	output logic [DramCmdPkg::DramMaskWidth-1:0] dramWrMask,
	output logic dramWrValid,
	input  logic dramWrReady
);

	logic isWrite; // Write command on offer
	logic wrSideOk; // Data present and write queue has room

	assign isWrite = CommandValid & (Command == DramCmdPkg::DramCmdWrite);
	assign wrSideOk = WriteDataValid & dramWrReady;

	assign dramCmd = Command;
	assign dramAddr = Address;
	assign dramWrData = WriteData;
	assign dramWrMask = WriteMask;

	// Reads go straight through, writes wait for the other channel
	assign dramCmdValid = CommandValid & (isWrite ? wrSideOk : 1'b1);
	assign CommandReady = dramCmdReady & (isWrite ? wrSideOk : 1'b1);

	// Data side only moves together with a write command
	assign dramWrValid = isWrite & WriteDataValid & dramCmdReady;
	assign WriteDataReady = isWrite & wrSideOk & dramCmdReady;

endmodule

//--- SynthDram.sv
// Synthetic DRAM for simulation: command and write-data queues, a masked word
// array and a fixed-latency read pipeline. Executes one command per cycle
module SynthDram (
	input  logic MemoryClock,
	input  logic arstN,

	input  logic [DramCmdPkg::DramCmdWidth-1:0] cmd,
	input  logic [DramCmdPkg::DramAddrWidth-1:0] addr,
	input  logic cmdValid,
	output logic cmdReady,

	input  logic [DramCmdPkg::DramDataWidth-1:0] wrData,
	input  logic [DramCmdPkg::DramMaskWidth-1:0] wrMask,
	input  logic wrValid,
	output logic wrReady,

	output logic [DramCmdPkg::DramDataWidth-1:0] ReadData,
	output logic ReadDataValid
);

	localparam int Lat = DramModelPkg::ReadLatency;

	DramCmdPkg::dramCmdEntry cmdIn;
	DramCmdPkg::dramCmdEntry cmdHead;
	DramCmdPkg::dramWriteEntry wrIn;
	DramCmdPkg::dramWriteEntry wrHead;

	logic cmdHeadValid;
	logic cmdPop;
	logic wrHeadValid;
	logic wrPop;
	logic headIsWrite;
	logic doWrite;
	logic doRead;

	logic [DramCmdPkg::DramDataWidth-1:0] mem [DramModelPkg::MemWords];

	logic [DramCmdPkg::DramDataWidth-1:0] pipeData [Lat];
	logic [Lat-1:0] pipeValid;

	// ------------------------------------------------------------------------
	// Input queues
	// ------------------------------------------------------------------------

	assign cmdIn = '{command: cmd, address: addr};
	assign wrIn = '{data: wrData, mask: wrMask};

	DramQueue #(
		.payloadType(DramCmdPkg::dramCmdEntry),
		.Depth(DramModelPkg::CmdQueueDepth)
	) cmdQueue (
		.MemoryClock(MemoryClock),
		.arstN(arstN),
		.pushValid(cmdValid),
		.pushData(cmdIn),
		.pushReady(cmdReady),
		.popValid(cmdHeadValid),
		.popData(cmdHead),
		.popReady(cmdPop)
	);

	DramQueue #(
		.payloadType(DramCmdPkg::dramWriteEntry),
		.Depth(DramModelPkg::WriteQueueDepth)
	) wrQueue (
		.MemoryClock(MemoryClock),
		.arstN(arstN),
		.pushValid(wrValid),
		.pushData(wrIn),
		.pushReady(wrReady),
		.popValid(wrHeadValid),
		.popData(wrHead),
		.popReady(wrPop)
	);

	// ------------------------------------------------------------------------
	// Command execution
	// ------------------------------------------------------------------------

	assign headIsWrite = (cmdHead.command == DramCmdPkg::DramCmdWrite);

	// A write needs its data at the head of the write queue
	assign doWrite = cmdHeadValid & headIsWrite & wrHeadValid;
	assign doRead = cmdHeadValid & ~headIsWrite;
	assign cmdPop = doWrite | doRead;
	assign wrPop = doWrite;

	// Byte-masked update, mask bit set keeps the stored byte
	always_ff @(posedge MemoryClock) begin
		if (doWrite) begin
			for (int b = 0; b < DramCmdPkg::DramMaskWidth; b++) begin
				if (!wrHead.mask[b])
					mem[cmdHead.address][b*8 +: 8] <= wrHead.data[b*8 +: 8];
			end
		end
	end

	// ------------------------------------------------------------------------
	// Read latency pipeline
	// ------------------------------------------------------------------------

	always_ff @(posedge MemoryClock) begin
		pipeData[0] <= mem[cmdHead.address];
		for (int i = 1; i < Lat; i++)
			pipeData[i] <= pipeData[i-1];
	end

	always_ff @(posedge MemoryClock or negedge arstN) begin
		if (!arstN)
			pipeValid <= '0;
		else
			pipeValid <= {pipeValid[Lat-2:0], doRead}; // Shift toward the output
	end

	assign ReadData = pipeData[Lat-1];
	assign ReadDataValid = pipeValid[Lat-1];

endmodule

//--- DramFrontEnd.sv
// Memory side top level: write join unit in front of the synthetic DRAM
// Requester drives separate command and write-data channels, reads come back in order
module DramFrontEnd (
	input  logic MemoryClock,
	input  logic arstN,

	// Command channel
	input  logic [DramCmdPkg::DramCmdWidth-1:0] Command,
	input  logic [DramCmdPkg::DramAddrWidth-1:0] Address,
	input  logic CommandValid,
	output logic CommandReady,

	// Write data channel
	input  logic [DramCmdPkg::DramDataWidth-1:0] WriteData,
	input  logic [DramCmdPkg::DramMaskWidth-1:0] WriteMask,
	input  logic WriteDataValid,
	output logic WriteDataReady,

	// Read return without back-pressure
	output logic [DramCmdPkg::DramDataWidth-1:0] ReadData,
	output logic ReadDataValid
);

	logic [DramCmdPkg::DramCmdWidth-1:0] dramCmd;
	logic [DramCmdPkg::DramAddrWidth-1:0] dramAddr;
	logic dramCmdValid;
	logic dramCmdReady;

	logic [DramCmdPkg::DramDataWidth-1:0] dramWrData;
	logic [DramCmdPkg::DramMaskWidth-1:0] dramWrMask;
	logic dramWrValid;
	logic dramWrReady;

	// ------------------------------------------------------------------------
	// Channel join
	// ------------------------------------------------------------------------

	WriteJoin writeJoin (
		.Command(Command),
		.Address(Address),
		.CommandValid(CommandValid),
		.CommandReady(CommandReady),
		.WriteData(WriteData),
		.WriteMask(WriteMask),
		.WriteDataValid(WriteDataValid),
		.WriteDataReady(WriteDataReady),
		.dramCmd(dramCmd),
		.dramAddr(dramAddr),
		.dramCmdValid(dramCmdValid),
		.dramCmdReady(dramCmdReady),
		.dramWrData(dramWrData),
		.dramWrMask(dramWrMask),
		.dramWrValid(dramWrValid),
		.dramWrReady(dramWrReady)
	);

	// ------------------------------------------------------------------------
	// Memory model
	// ------------------------------------------------------------------------

	SynthDram dram (
		.MemoryClock(MemoryClock),
		.arstN(arstN),
		.cmd(dramCmd),
		.addr(dramAddr),
		.cmdValid(dramCmdValid),
		.cmdReady(dramCmdReady),
		.wrData(dramWrData),
		.wrMask(dramWrMask),
		.wrValid(dramWrValid),
		.wrReady(dramWrReady),
		.ReadData(ReadData),
		.ReadDataValid(ReadDataValid)
	);

endmodule

//--- TbClockGen.sv
// Clock and reset source for the DRAM front end testbench
// Free-running MemoryClock, arstN held low for a fixed number of cycles
module TbClockGen #(
	parameter real PeriodNs = 8.0,
	parameter int ResetCycles = 16
) (
	output logic MemoryClock,
	output logic arstN
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		MemoryClock = 1'b0;
		forever #(PeriodNs / 2.0) MemoryClock = ~MemoryClock;
	end

	initial begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge MemoryClock);
		#2 arstN = 1'b1; // Release away from the edge
	end

endmodule

//--- TbDramFrontEnd.sv
// Testbench for the DRAM front end covering writes, masked writes, late write data and
// random mixed traffic, with read data checked against a local word array
module TbDramFrontEnd;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int Lat = DramModelPkg::ReadLatency;
	localparam int AW = DramCmdPkg::DramAddrWidth;
	localparam int DW = DramCmdPkg::DramDataWidth;
	localparam int MW = DramCmdPkg::DramMaskWidth;
	localparam int FillWords = 32;
	localparam int RandomOps = 64;
	localparam int LateCycles = 6;
	// Every command issued over all tests
	localparam int TotalCmds = 4 * FillWords + 3 + RandomOps;
	localparam int TimeoutCycles = TotalCmds * (Lat + 8);

	logic MemoryClock;
	logic arstN;
	logic [DramCmdPkg::DramCmdWidth-1:0] Command;
	logic [AW-1:0] Address;
	logic CommandValid;
	logic CommandReady;
	logic [DW-1:0] WriteData;
	logic [MW-1:0] WriteMask;
	logic WriteDataValid;
	logic WriteDataReady;
	logic [DW-1:0] ReadData;
	logic ReadDataValid;

	integer seed = 32'hdce3;
	int cycleCount = 0;
	int dataErrors = 0;
	int latencyErrors = 0;
	int protocolErrors = 0;
	int acceptedReads = 0;
	int returnedReads = 0;

	logic [DW-1:0] refMem [DramModelPkg::MemWords]; // Model of the word array
	logic [DW-1:0] expQ [$];
	string nameQ [$];
	int acceptQ [$];

	logic [DW-1:0] expWord;
	string expName;
	int expCycle;

	TbClockGen #(.PeriodNs(8.0), .ResetCycles(16)) clockGen (
		.MemoryClock(MemoryClock),
		.arstN(arstN)
	);

	DramFrontEnd uut (
		.MemoryClock(MemoryClock),
		.arstN(arstN),
		.Command(Command),
		.Address(Address),
		.CommandValid(CommandValid),
		.CommandReady(CommandReady),
		.WriteData(WriteData),
		.WriteMask(WriteMask),
		.WriteDataValid(WriteDataValid),
		.WriteDataReady(WriteDataReady),
		.ReadData(ReadData),
		.ReadDataValid(ReadDataValid)
	);

	// ------------------------------------------------------------------------
	// Reference model and helpers
	// ------------------------------------------------------------------------

	// Set mask bit keeps the old byte
	function automatic logic [DW-1:0] refWrite(input logic [DW-1:0] oldWord,
			input logic [DW-1:0] newWord, input logic [MW-1:0] mask);
		logic [DW-1:0] merged;
		merged = oldWord;
		for (int b = 0; b < MW; b++) begin
			if (!mask[b])
				merged[b*8 +: 8] = newWord[b*8 +: 8];
		end
		return merged;
	endfunction

	always @(posedge MemoryClock)
		cycleCount <= cycleCount + 1;

	task automatic tick();
		@(posedge MemoryClock);
		#1; // Inputs change 1 ns after the edge
	endtask

	task automatic issueWrite(input logic [AW-1:0] a, input logic [DW-1:0] d,
			input logic [MW-1:0] m);
		logic accepted;
		accepted = 1'b0;
		Command = DramCmdPkg::DramCmdWrite;
		Address = a;
		CommandValid = 1'b1;
		WriteData = d;
		WriteMask = m;
		WriteDataValid = 1'b1;
		while (!accepted) begin
			#6; // Just before the next edge
			assert (CommandReady == WriteDataReady) else begin
				$display("Command and write data readies disagree for a write at %0t", $time);
				protocolErrors++;
			end
			accepted = CommandReady && WriteDataReady;
			tick();
		end
		CommandValid = 1'b0;
		WriteDataValid = 1'b0;
		refMem[a] = refWrite(refMem[a], d, m);
	endtask

	task automatic issueRead(input logic [AW-1:0] a, input string name);
		logic accepted;
		accepted = 1'b0;
		Command = DramCmdPkg::DramCmdRead;
		Address = a;
		CommandValid = 1'b1;
		while (!accepted) begin
			#6;
			accepted = CommandReady;
			tick();
		end
		CommandValid = 1'b0;
		expQ.push_back(refMem[a]); // Value as of acceptance
		nameQ.push_back(name);
		acceptQ.push_back(cycleCount);
		acceptedReads++;
	endtask

	// ------------------------------------------------------------------------
	// Read compare
	// ------------------------------------------------------------------------

	always @(posedge MemoryClock) begin
		if (arstN && ReadDataValid) begin
			returnedReads++;
			if (expQ.size() == 0) begin
				$display("Read data returned with no read outstanding at %0t", $time);
				protocolErrors++;
			end else begin
				expWord = expQ.pop_front();
				expName = nameQ.pop_front();
				expCycle = acceptQ.pop_front();
				assert (ReadData === expWord) else begin
					$display("CHECK FAILED %s expected %h actual %h", expName, expWord,
						ReadData);
					dataErrors++;
				end
				// cycleCount + 1 is the number of this edge
				assert (cycleCount + 1 - expCycle >= Lat + 1) else begin
					$display("CHECK FAILED %s latency expected >= %0d actual %0d", expName,
						Lat + 1, cycleCount + 1 - expCycle);
					latencyErrors++;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Watchdog
	// ------------------------------------------------------------------------

	initial begin
		repeat (TimeoutCycles + 16) @(posedge MemoryClock);
		$display("Timeout after %0d cycles, reads outstanding %0d", cycleCount, expQ.size());
		$display("Test failed");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	initial begin
		logic [31:0] r;
		logic [DW-1:0] d;
		logic [AW-1:0] a;
		int totalErrors;
		Command = '0;
		Address = '0;
		CommandValid = 1'b0;
		WriteData = '0;
		WriteMask = '0;
		WriteDataValid = 1'b0;
		wait (arstN === 1'b1);
		tick();

		// Full words then read back
		for (int i = 0; i < FillWords; i++) begin
			d = {$random(seed), $random(seed)};
			issueWrite(AW'(i), d, '0);
		end
		for (int i = 0; i < FillWords; i++)
			issueRead(AW'(i), "fullWrite");

		// Random byte masks over the same words
		for (int i = 0; i < FillWords; i++) begin
			d = {$random(seed), $random(seed)};
			r = $random(seed);
			issueWrite(AW'(i), d, r[MW-1:0]);
		end
		for (int i = 0; i < FillWords; i++)
			issueRead(AW'(i), "byteMask");

		// Write command waits for its data
		a = AW'(5);
		d = {$random(seed), $random(seed)};
		issueRead(a, "lateData");
		Command = DramCmdPkg::DramCmdWrite;
		Address = a;
		CommandValid = 1'b1;
		WriteData = d;
		WriteMask = '0;
		WriteDataValid = 1'b0;
		repeat (LateCycles) begin
			#6;
			assert (!CommandReady && !WriteDataReady) else begin
				$display("Ready high for a write command without write data at %0t", $time);
				protocolErrors++;
			end
			tick();
		end
		issueWrite(a, d, '0);
		issueRead(a, "lateData");

		// Mixed traffic back to back
		for (int i = 0; i < RandomOps; i++) begin
			r = $random(seed);
			a = AW'(r[5:1]); // Only written addresses
			if (r[0]) begin
				issueRead(a, "backPressure");
			end else begin
				d = {$random(seed), $random(seed)};
				issueWrite(a, d, r[15:8]);
			end
		end

		// Drain, then watch for stray pulses
		while (expQ.size() != 0)
			tick();
		repeat (Lat + 8) tick();

		assert (returnedReads == acceptedReads) else begin
			$display("CHECK FAILED readCount expected %0d actual %0d", acceptedReads,
				returnedReads);
			dataErrors++;
		end

		totalErrors = dataErrors + latencyErrors + protocolErrors;
		$display("Errors: data %0d, latency %0d, protocol %0d, reads %0d", dataErrors,
			latencyErrors, protocolErrors, returnedReads);
		if (totalErrors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- list.f
DramCmdPkg.sv
DramModelPkg.sv
DramQueue.sv
WriteJoin.sv
SynthDram.sv
DramFrontEnd.sv
TbClockGen.sv
TbDramFrontEnd.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and fail if the log reports a failure
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module TbDramFrontEnd -o simv \
	&& ./obj_dir/simv > sim.log \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
